// File: design/mem_pipe_config.svh
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// Data and address width
`define XLEN 32

// Window segment, taken from the top address bits
`define SEG_W 3

// Destination register index
`define RIDX_W 5

`endif

// File: design/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ALU   = 3'd1,  // Writes the execute result
        OP_LINK  = 3'd2,  // Writes pc + 4
        OP_LOAD  = 3'd3,
        OP_STORE = 3'd4
    } op_kind_t;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_t;

    typedef enum logic [2:0] {
        EX_NONE     = 3'd0,
        EX_ALE      = 3'd1,  // Misaligned access
        EX_TRANS    = 3'd2,  // Outside the mapped window
        EX_UPSTREAM = 3'd3   // Carried in from earlier stages
    } excp_code_t;

    function automatic logic is_mem_op(op_kind_t kind);
        return kind == OP_LOAD || kind == OP_STORE;
    endfunction

    // Operations that produce a register result
    function automatic logic writes_rd(op_kind_t kind);
        return kind == OP_ALU || kind == OP_LINK || kind == OP_LOAD;
    endfunction

endpackage

// File: design/bus_pkg.sv
`include "mem_pipe_config.svh"

package bus_pkg;

    // Wishbone byte select, one bit per lane
    typedef logic [3:0] sel_t;

    typedef logic [`XLEN-3:0] word_addr_t;

    // Byte address split into the bus word and the lane inside it
    typedef struct packed {
        word_addr_t word;
        logic [1:0] lane;
    } byte_addr_t;

endpackage

// File: design/addr_trans.sv
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module addr_trans
    import pipe_pkg::*;
    import bus_pkg::*;
(
    input  logic [`XLEN-1:0]  va,
    input  size_t             size,
    input  logic              da,
    input  logic [`SEG_W-1:0] dmw_vseg,
    input  logic [`SEG_W-1:0] dmw_pseg,
    output logic [`XLEN-1:0]  pa,
    output sel_t              sel,
    output excp_code_t        excp_code
);

    byte_addr_t va_s;
    logic       misaligned;
    logic       in_window;

    assign va_s = va;
    assign in_window = va[`XLEN-1 -: `SEG_W] == dmw_vseg;

    // Segment bits replaced, offset kept
    assign pa = da ? va : {dmw_pseg, va[`XLEN-`SEG_W-1:0]};

    always_comb begin
        case (size)
            SZ_BYTE: begin
                misaligned = 1'b0;
                sel = 4'b0001 << va_s.lane;
            end
            SZ_HALF: begin
                misaligned = va_s.lane[0];
                sel = 4'b0011 << {va_s.lane[1], 1'b0};
            end
            default: begin
                misaligned = va_s.lane != 2'b00;
                sel = 4'b1111;
            end
        endcase
    end

    // Alignment is reported ahead of the window check
    always_comb begin
        if (misaligned)
            excp_code = EX_ALE;
        else if (!da && !in_window)
            excp_code = EX_TRANS;
        else
            excp_code = EX_NONE;
    end

endmodule

// File: design/mem1_stage.sv
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module mem1_stage
    import pipe_pkg::*;
    import bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,

    input  logic               in_valid,
    input  op_kind_t           in_kind,
    input  size_t              in_size,
    input  logic               in_signed,
    input  logic [`XLEN-1:0]   in_pc,
    input  logic [`XLEN-1:0]   in_ex_out,
    input  logic [`XLEN-1:0]   in_store_data,
    input  logic [`RIDX_W-1:0] in_rd,
    input  logic               in_excp_valid,
    input  excp_code_t         in_excp_code,

    input  logic               csr_da,
    input  logic [`SEG_W-1:0]  csr_dmw_vseg,
    input  logic [`SEG_W-1:0]  csr_dmw_pseg,

    output logic               fwd_valid,
    output logic               fwd_load,
    output logic [`RIDX_W-1:0] fwd_rd,
    output logic [`XLEN-1:0]   fwd_data,

    output logic               m1_valid,
    output op_kind_t           m1_kind,
    output size_t              m1_size,
    output logic               m1_signed,
    output logic [`XLEN-1:0]   m1_pa,
    output logic [`XLEN-1:0]   m1_store_data,
    output sel_t               m1_sel,
    output logic [`RIDX_W-1:0] m1_rd,
    output logic [`XLEN-1:0]   m1_link_val,
    output logic               m1_excp_valid,
    output excp_code_t         m1_excp_code,
    output logic [`XLEN-1:0]   m1_badv
);

    logic               valid_r;
    op_kind_t           kind_r;
    size_t              size_r;
    logic               signed_r;
    logic [`XLEN-1:0]   pc_r;
    logic [`XLEN-1:0]   ex_out_r;
    logic [`XLEN-1:0]   store_data_r;
    logic [`RIDX_W-1:0] rd_r;
    logic               excp_valid_r;
    excp_code_t         excp_code_r;
    sel_t               trans_sel;
    excp_code_t         trans_code;
    logic               trans_fault;
    logic               mem_op;

    always_ff @(posedge clk) begin
        if (!rst_n || flush)
            valid_r <= 1'b0;
        else if (!stall)
            valid_r <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            kind_r       <= in_kind;
            size_r       <= in_size;
            signed_r     <= in_signed;
            pc_r         <= in_pc;
            ex_out_r     <= in_ex_out;
            store_data_r <= in_store_data;
            rd_r         <= in_rd;
            excp_valid_r <= in_excp_valid;
            excp_code_r  <= in_excp_code;
        end
    end

    addr_trans addr_trans_i (
        .va        (ex_out_r),
        .size      (size_r),
        .da        (csr_da),
        .dmw_vseg  (csr_dmw_vseg),
        .dmw_pseg  (csr_dmw_pseg),
        .pa        (m1_pa),
        .sel       (trans_sel),
        .excp_code (trans_code)
    );

    assign mem_op = is_mem_op(kind_r);
    assign trans_fault = mem_op && trans_code != EX_NONE;

    // Upstream exception keeps priority over translation
    assign m1_excp_valid = excp_valid_r || trans_fault;
    assign m1_excp_code = excp_valid_r ? excp_code_r : (trans_fault ? trans_code : EX_NONE);
    assign m1_badv = ex_out_r;

    assign m1_valid = valid_r;
    assign m1_kind = kind_r;
    assign m1_size = size_r;
    assign m1_signed = signed_r;
    assign m1_rd = rd_r;
    assign m1_link_val = fwd_data;  // ALU or LINK result for writeback
    assign m1_store_data = store_data_r << {ex_out_r[1:0], 3'b000};

    assign m1_sel = (mem_op && !m1_excp_valid) ? trans_sel : '0;

    assign fwd_valid = valid_r && writes_rd(kind_r) && !m1_excp_valid;
    assign fwd_load = kind_r == OP_LOAD;  // Data arrives only in mem2
    assign fwd_rd = rd_r;
    assign fwd_data = (kind_r == OP_LINK) ? pc_r + `XLEN'd4 : ex_out_r;

    // Held operation waits for mem2 to free up
    assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(m1_valid) && $stable(m1_kind) && $stable(m1_badv))
        else $error("mem1: operation changed during stall");

endmodule

// File: design/mem2_stage.sv
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module mem2_stage
    import pipe_pkg::*;
    import bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,

    input  logic               m1_valid,
    input  op_kind_t           m1_kind,
    input  size_t              m1_size,
    input  logic               m1_signed,
    input  logic [`XLEN-1:0]   m1_pa,
    input  logic [`XLEN-1:0]   m1_store_data,
    input  sel_t               m1_sel,
    input  logic [`RIDX_W-1:0] m1_rd,
    input  logic [`XLEN-1:0]   m1_link_val,
    input  logic               m1_excp_valid,
    input  excp_code_t         m1_excp_code,
    input  logic [`XLEN-1:0]   m1_badv,

    output logic               stall,

    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output word_addr_t         wb_adr,
    output logic [`XLEN-1:0]   wb_dat_w,
    output sel_t               wb_sel,
    input  logic [`XLEN-1:0]   wb_dat_r,
    input  logic               wb_ack,

    output logic               wbk_valid,
    output logic               wbk_rd_we,
    output logic [`RIDX_W-1:0] wbk_rd,
    output logic [`XLEN-1:0]   wbk_data,
    output logic               wbk_excp_valid,
    output excp_code_t         wbk_excp_code,
    output logic [`XLEN-1:0]   wbk_badv
);

    logic               valid_r;
    logic               cyc_r;
    op_kind_t           kind_r;
    size_t              size_r;
    logic               signed_r;
    byte_addr_t         pa_r;
    logic [`XLEN-1:0]   store_data_r;
    sel_t               sel_r;
    logic [`RIDX_W-1:0] rd_r;
    logic [`XLEN-1:0]   link_val_r;
    logic               excp_valid_r;
    excp_code_t         excp_code_r;
    logic [`XLEN-1:0]   badv_r;
    logic               bus_req;
    logic               done;
    logic [`XLEN-1:0]   rdata_sh;
    logic [`XLEN-1:0]   load_data;

    assign bus_req = m1_valid && is_mem_op(m1_kind) && !m1_excp_valid;
    assign stall = cyc_r && !wb_ack;
    assign done = valid_r && (!cyc_r || wb_ack);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            cyc_r   <= 1'b0;
        end else if (!stall) begin
            valid_r <= m1_valid && !flush;
            cyc_r   <= bus_req && !flush;
        end else if (flush) begin
            valid_r <= 1'b0;  // Bus cycle runs on, its result is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            kind_r       <= m1_kind;
            size_r       <= m1_size;
            signed_r     <= m1_signed;
            pa_r         <= m1_pa;
            store_data_r <= m1_store_data;
            sel_r        <= m1_sel;
            rd_r         <= m1_rd;
            link_val_r   <= m1_link_val;
            excp_valid_r <= m1_excp_valid;
            excp_code_r  <= m1_excp_code;
            badv_r       <= m1_badv;
        end
    end

    assign wb_cyc = cyc_r;
    assign wb_stb = cyc_r;  // Classic cycle, one transfer per cyc
    assign wb_we = kind_r == OP_STORE;
    assign wb_adr = pa_r.word;
    assign wb_dat_w = store_data_r;
    assign wb_sel = sel_r;

    assign rdata_sh = wb_dat_r >> {pa_r.lane, 3'b000};

    always_comb begin
        case (size_r)
            SZ_BYTE: load_data = {{(`XLEN-8){signed_r & rdata_sh[7]}}, rdata_sh[7:0]};
            SZ_HALF: load_data = {{(`XLEN-16){signed_r & rdata_sh[15]}}, rdata_sh[15:0]};
            default: load_data = rdata_sh;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            wbk_valid <= 1'b0;
        else
            wbk_valid <= done && !flush;
    end

    always_ff @(posedge clk) begin
        if (done) begin
            wbk_rd_we      <= !excp_valid_r && writes_rd(kind_r) && rd_r != '0;
            wbk_rd         <= rd_r;
            wbk_data       <= (kind_r == OP_LOAD) ? load_data : link_val_r;
            wbk_excp_valid <= excp_valid_r;
            wbk_excp_code  <= excp_code_r;
            wbk_badv       <= badv_r;
        end
    end

    // Only a memory op free of exceptions owns the bus
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc |-> is_mem_op(kind_r) && !excp_valid_r)
        else $error("mem2: bus cycle for a non-memory or faulting op");

    // Slave sees a steady request until it answers
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel))
        else $error("mem2: bus request changed before ack");

endmodule

// File: design/mem_pipe_top.sv
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module mem_pipe_top
    import pipe_pkg::*;
    import bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    output logic               stall,

    input  logic               in_valid,
    input  op_kind_t           in_kind,
    input  size_t              in_size,
    input  logic               in_signed,
    input  logic [`XLEN-1:0]   in_pc,
    input  logic [`XLEN-1:0]   in_ex_out,
    input  logic [`XLEN-1:0]   in_store_data,
    input  logic [`RIDX_W-1:0] in_rd,
    input  logic               in_excp_valid,
    input  excp_code_t         in_excp_code,

    input  logic               csr_da,
    input  logic [`SEG_W-1:0]  csr_dmw_vseg,
    input  logic [`SEG_W-1:0]  csr_dmw_pseg,

    output logic               fwd_valid,
    output logic               fwd_load,
    output logic [`RIDX_W-1:0] fwd_rd,
    output logic [`XLEN-1:0]   fwd_data,

    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output word_addr_t         wb_adr,
    output logic [`XLEN-1:0]   wb_dat_w,
    output sel_t               wb_sel,
    input  logic [`XLEN-1:0]   wb_dat_r,
    input  logic               wb_ack,

    output logic               wbk_valid,
    output logic               wbk_rd_we,
    output logic [`RIDX_W-1:0] wbk_rd,
    output logic [`XLEN-1:0]   wbk_data,
    output logic               wbk_excp_valid,
    output excp_code_t         wbk_excp_code,
    output logic [`XLEN-1:0]   wbk_badv
);

    // Stage hand-off
    logic               m1_valid;
    op_kind_t           m1_kind;
    size_t              m1_size;
    logic               m1_signed;
    logic [`XLEN-1:0]   m1_pa;
    logic [`XLEN-1:0]   m1_store_data;
    sel_t               m1_sel;
    logic [`RIDX_W-1:0] m1_rd;
    logic [`XLEN-1:0]   m1_link_val;
    logic               m1_excp_valid;
    excp_code_t         m1_excp_code;
    logic [`XLEN-1:0]   m1_badv;

    mem1_stage mem1_stage_i (.*);

    mem2_stage mem2_stage_i (.*);

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;

    always #4 clk = ~clk;  // 8 ns period

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module wb_mem_model
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  word_addr_t       adr,
    input  logic [`XLEN-1:0] dat_w,
    input  sel_t             sel,
    output logic [`XLEN-1:0] dat_r,
    output logic             ack
);

    logic [`XLEN-1:0] mem [word_addr_t];
    logic             pending;
    int               wait_cnt;
    logic [`XLEN-1:0] word;

    // Untouched words read back a pattern of their own address
    function automatic logic [`XLEN-1:0] fill_word(word_addr_t w);
        return {w, 2'b00} ^ 32'h9e37_79b9;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            dat_r   <= '0;
            pending = 1'b0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            if (!pending) begin
                pending  = 1'b1;
                wait_cnt = $urandom_range(3, 0);
            end
            if (wait_cnt == 0) begin
                pending = 1'b0;
                word = mem.exists(adr) ? mem[adr] : fill_word(adr);
                if (we) begin
                    for (int i = 0; i < 4; i++)
                        if (sel[i]) word[8*i +: 8] = dat_w[8*i +: 8];
                    mem[adr] = word;
                end
                dat_r <= word;
                ack   <= 1'b1;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

endmodule

// File: bench/tb_mem_pipe.sv
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module tb_mem_pipe
    import pipe_pkg::*;
    import bus_pkg::*;
;

    typedef struct {
        logic               rd_we;
        logic [`RIDX_W-1:0] rd;
        logic [`XLEN-1:0]   data;
        logic               chk_data;
        logic               excp_valid;
        excp_code_t         code;
        logic [`XLEN-1:0]   badv;
    } wb_exp_t;

    logic clk, rst_n, flush, stall;
    logic in_valid, in_signed, in_excp_valid;
    op_kind_t in_kind;
    size_t in_size;
    logic [`XLEN-1:0] in_pc, in_ex_out, in_store_data;
    logic [`RIDX_W-1:0] in_rd;
    excp_code_t in_excp_code;
    logic csr_da;
    logic [`SEG_W-1:0] csr_vseg, csr_pseg;
    logic fwd_valid, fwd_load;
    logic [`RIDX_W-1:0] fwd_rd;
    logic [`XLEN-1:0] fwd_data;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    word_addr_t wb_adr;
    logic [`XLEN-1:0] wb_dat_w, wb_dat_r;
    sel_t wb_sel;
    logic wbk_valid, wbk_rd_we, wbk_excp_valid;
    logic [`RIDX_W-1:0] wbk_rd;
    logic [`XLEN-1:0] wbk_data, wbk_badv;
    excp_code_t wbk_excp_code;

    wb_exp_t expq[$];
    wb_exp_t got_e;
    logic [`XLEN-1:0] shadow [word_addr_t];
    int n_issued = 0;
    int cycles = 0;

    clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    wb_mem_model wb_mem_model_i (
        .clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_w), .sel(wb_sel), .dat_r(wb_dat_r), .ack(wb_ack)
    );

    mem_pipe_top dut_i (
        .csr_dmw_vseg(csr_vseg), .csr_dmw_pseg(csr_pseg), .*
    );

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] got);
        if (exp !== got)
            stop_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
    endtask

    task automatic check_rd(string name, logic [`RIDX_W-1:0] exp, logic [`RIDX_W-1:0] got);
        if (exp !== got)
            stop_run($sformatf("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got));
    endtask

    task automatic check_excp(string name, excp_code_t exp, excp_code_t got);
        if (exp !== got)
            stop_run($sformatf("Mismatch at %0t: %s expected %s got %s",
                               $time, name, exp.name(), got.name()));
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        if (exp !== got)
            stop_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
    endtask

    function automatic logic [`XLEN-1:0] shadow_read(word_addr_t w);
        return shadow.exists(w) ? shadow[w] : ({w, 2'b00} ^ 32'h9e37_79b9);
    endfunction

    // Expected writeback; stores update the shadow memory
    function automatic wb_exp_t reference(op_kind_t kind, size_t size, logic sgn,
            logic [`XLEN-1:0] pc, logic [`XLEN-1:0] va, logic [`XLEN-1:0] sdata,
            logic [`RIDX_W-1:0] rd, logic uexc);
        wb_exp_t e;
        logic [`XLEN-1:0] pa;
        logic [`XLEN-1:0] word;
        logic [1:0] lane;
        excp_code_t tcode;
        int nb;
        e.rd = rd;
        e.badv = va;
        e.excp_valid = 1'b0;
        e.code = EX_NONE;
        e.data = '0;
        e.chk_data = 1'b0;
        lane = va[1:0];
        pa = csr_da ? va : {csr_pseg, va[`XLEN-`SEG_W-1:0]};
        if ((size == SZ_HALF && lane[0]) || (size == SZ_WORD && lane != 2'b00))
            tcode = EX_ALE;
        else if (!csr_da && va[`XLEN-1 -: `SEG_W] != csr_vseg)
            tcode = EX_TRANS;
        else
            tcode = EX_NONE;
        if (uexc) begin
            e.excp_valid = 1'b1;
            e.code = EX_UPSTREAM;
        end else if ((kind == OP_LOAD || kind == OP_STORE) && tcode != EX_NONE) begin
            e.excp_valid = 1'b1;
            e.code = tcode;
        end
        if (!e.excp_valid) begin
            word = shadow_read(pa[`XLEN-1:2]);
            case (kind)
                OP_ALU: begin
                    e.data = va;
                    e.chk_data = 1'b1;
                end
                OP_LINK: begin
                    e.data = pc + 4;
                    e.chk_data = 1'b1;
                end
                OP_LOAD: begin
                    word = word >> (8 * lane);
                    e.chk_data = 1'b1;
                    if (size == SZ_BYTE)
                        e.data = {{24{sgn & word[7]}}, word[7:0]};
                    else if (size == SZ_HALF)
                        e.data = {{16{sgn & word[15]}}, word[15:0]};
                    else
                        e.data = word;
                end
                OP_STORE: begin
                    nb = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
                    for (int i = 0; i < nb; i++)
                        word[8*(lane+i) +: 8] = sdata[8*i +: 8];
                    shadow[pa[`XLEN-1:2]] = word;
                end
                default: ;
            endcase
        end
        e.rd_we = !e.excp_valid && rd != '0 &&
                  (kind == OP_ALU || kind == OP_LINK || kind == OP_LOAD);
        return e;
    endfunction

    // Called 1 ns after an edge; returns 1 ns after the accepting edge
    task automatic issue(op_kind_t kind, size_t size, logic sgn, logic [`XLEN-1:0] va,
            logic [`XLEN-1:0] sdata, logic [`RIDX_W-1:0] rd, logic uexc, logic keep);
        wb_exp_t e;
        logic [`XLEN-1:0] pc;
        logic accepted;
        logic fwd_exp;
        pc = $urandom & ~32'h3;
        e = reference(kind, size, sgn, pc, va, sdata, rd, uexc);
        if (keep)
            expq.push_back(e);
        n_issued++;
        in_valid = 1'b1;
        in_kind = kind;
        in_size = size;
        in_signed = sgn;
        in_pc = pc;
        in_ex_out = va;
        in_store_data = sdata;
        in_rd = rd;
        in_excp_valid = uexc;
        in_excp_code = uexc ? EX_UPSTREAM : EX_NONE;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
        end
        #1 in_valid = 1'b0;
        // Forwarding view while the op sits in mem1
        fwd_exp = !e.excp_valid && (kind == OP_ALU || kind == OP_LINK || kind == OP_LOAD);
        check_flag("fwd_valid", fwd_exp, fwd_valid);
        check_flag("fwd_load", kind == OP_LOAD, fwd_load);
        if (fwd_exp) begin
            check_rd("fwd_rd", rd, fwd_rd);
            check_data("fwd_data", (kind == OP_LINK) ? pc + 4 : va, fwd_data);
        end
    endtask

    task automatic drain();
        while (expq.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    function automatic logic [`XLEN-1:0] rand_addr(logic [`XLEN-1:0] base, size_t size);
        logic [1:0] lane;
        lane = $urandom_range(3, 0);
        if (size == SZ_HALF)
            lane[0] = 1'b0;
        else if (size == SZ_WORD)
            lane = 2'b00;
        return base | ($urandom_range(15, 0) << 2) | lane;
    endfunction

    always @(negedge clk) begin
        if (rst_n && wbk_valid) begin
            if (expq.size() == 0) begin
                stop_run("A writeback arrived with no operation outstanding");
            end else begin
                got_e = expq.pop_front();
                check_flag("wbk_excp_valid", got_e.excp_valid, wbk_excp_valid);
                check_flag("wbk_rd_we", got_e.rd_we, wbk_rd_we);
                check_rd("wbk_rd", got_e.rd, wbk_rd);
                if (got_e.excp_valid) begin
                    check_excp("wbk_excp_code", got_e.code, wbk_excp_code);
                    check_data("wbk_badv", got_e.badv, wbk_badv);
                end
                if (got_e.chk_data)
                    check_data("wbk_data", got_e.data, wbk_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 20 * n_issued + 100)
            stop_run("Timeout: the pipeline stopped producing writebacks");
    end

    initial begin
        size_t sz;
        logic [`XLEN-1:0] va;
        void'($urandom(32'hc686_578a));
        flush = 1'b0;
        in_valid = 1'b0;
        in_kind = OP_NOP;
        in_size = SZ_WORD;
        in_signed = 1'b0;
        in_pc = '0;
        in_ex_out = '0;
        in_store_data = '0;
        in_rd = '0;
        in_excp_valid = 1'b0;
        in_excp_code = EX_NONE;
        csr_da = 1'b1;
        csr_vseg = 3'b101;
        csr_pseg = 3'b001;
        wait (rst_n);
        @(posedge clk);
        #1;
        // Idle outputs out of reset
        check_flag("wbk_valid", 1'b0, wbk_valid);
        check_flag("wb_cyc", 1'b0, wb_cyc);
        check_flag("wb_stb", 1'b0, wb_stb);
        check_flag("fwd_valid", 1'b0, fwd_valid);
        check_flag("stall", 1'b0, stall);
        // ALU and LINK with some writes to register 0
        for (int i = 0; i < 12; i++)
            issue((i % 3 == 0) ? OP_LINK : OP_ALU, SZ_WORD, 1'b0, $urandom, '0,
                  (i % 4 == 0) ? '0 : $urandom_range(31, 1), 1'b0, 1'b1);
        // Mixed stores and loads in a small region
        for (int i = 0; i < 60; i++) begin
            sz = size_t'($urandom_range(2, 0));
            issue((i < 20 || $urandom_range(1, 0)) ? OP_STORE : OP_LOAD, sz,
                  $urandom_range(1, 0), rand_addr(32'h0000_1000, sz), $urandom,
                  $urandom_range(31, 1), 1'b0, 1'b1);
        end
        // Misaligned access alone in the pipeline
        drain();
        issue(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_1002, '0, 5'd7, 1'b0, 1'b1);
        repeat (4) begin
            @(negedge clk);
            check_flag("wb_cyc", 1'b0, wb_cyc);
            check_flag("wb_stb", 1'b0, wb_stb);
        end
        @(posedge clk);
        #1;
        issue(OP_STORE, SZ_HALF, 1'b0, 32'h0000_1001, $urandom, 5'd3, 1'b0, 1'b1);
        drain();
        // Window mode
        csr_da = 1'b0;
        for (int i = 0; i < 16; i++) begin
            sz = size_t'($urandom_range(2, 0));
            issue($urandom_range(1, 0) ? OP_STORE : OP_LOAD, sz, $urandom_range(1, 0),
                  rand_addr(32'hA000_2000, sz), $urandom, 5'd9, 1'b0, 1'b1);
        end
        issue(OP_LOAD, SZ_WORD, 1'b0, 32'h4000_2000, '0, 5'd4, 1'b0, 1'b1);
        issue(OP_STORE, SZ_WORD, 1'b0, 32'h4000_2002, '0, 5'd4, 1'b0, 1'b1);
        issue(OP_LOAD, SZ_WORD, 1'b0, 32'h4000_2000, '0, 5'd4, 1'b1, 1'b1);
        issue(OP_STORE, SZ_WORD, 1'b0, 32'h4000_2002, '0, 5'd4, 1'b1, 1'b1);
        issue(OP_LOAD, SZ_WORD, 1'b0, 32'hA000_2004, '0, 5'd4, 1'b1, 1'b1);
        drain();
        // Remapped data seen through direct loads
        csr_da = 1'b1;
        for (int i = 0; i < 16; i++)
            issue(OP_LOAD, SZ_WORD, 1'b0, 32'h2000_2000 | (i << 2), '0, 5'd11, 1'b0, 1'b1);
        drain();
        // Flush with a store on the bus and an ALU op in mem1
        for (int i = 0; i < 6; i++) begin
            va = rand_addr(32'h0000_3000, SZ_WORD);
            issue(OP_STORE, SZ_WORD, 1'b0, va, $urandom, 5'd1, 1'b0, 1'b0);
            issue(OP_ALU, SZ_WORD, 1'b0, $urandom, '0, 5'd2, 1'b0, 1'b0);
            flush = 1'b1;
            @(posedge clk);
            #1 flush = 1'b0;
            issue(OP_LOAD, SZ_WORD, 1'b0, va, '0, 5'd5, 1'b0, 1'b1);
            issue(OP_ALU, SZ_WORD, 1'b0, $urandom, '0, 5'd6, 1'b0, 1'b1);
            drain();
        end
        drain();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/pipe_pkg.sv
design/bus_pkg.sv
design/addr_trans.sv
design/mem1_stage.sv
design/mem2_stage.sv
design/mem_pipe_top.sv
bench/clk_gen.sv
bench/wb_mem_model.sv
bench/tb_mem_pipe.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_pipe
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(filter-out +%,$(shell cat src.f))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
